//--- build.f
verilog/noc_pkg.sv
verilog/noc_fifo.sv
verilog/noc_router_input.sv
verilog/noc_router_output.sv
verilog/noc_router.sv
verification/noc_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the NoC router testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module noc_router_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vnoc_router_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   echo "Testbench reported failure"
   exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
   echo "Testbench did not reach its final report"
   exit 1
fi

echo "Testbench passed"
exit 0

//--- verification/noc_router_tb.sv
/* NoC router testbench
   Packet streams on all inputs, scoreboard assertions on every output */
`timescale 1ns/1ps

module noc_router_tb;

   localparam int CLK_PERIOD = 40;
   // 4 sources, 4 + 6 + 6 + 10 packets each, up to 4 flits per packet
   localparam int MAX_FLITS  = 4 * (4 + 6 + 6 + 10) * 4;
   localparam int MODE_ALL_DEST = 0;
   localparam int MODE_HOTSPOT  = 1;
   localparam int MODE_FAIR     = 2;
   localparam int MODE_RANDOM   = 3;

   logic                                    clk;
   logic                                    arst_n;
   noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] in_link;
   noc_pkg::port_mask_t                     in_valid;
   noc_pkg::port_mask_t                     in_ready;
   noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] out_link;
   noc_pkg::port_mask_t                     out_valid;
   noc_pkg::port_mask_t                     out_ready;

   // Expected flits per source and output pair, index src * NUM_PORTS + out
   noc_pkg::link_t exp_q [noc_pkg::NUM_PORTS*noc_pkg::NUM_PORTS][$];
   int             rd_idx [noc_pkg::NUM_PORTS*noc_pkg::NUM_PORTS];
   // Packets of other sources seen while a source waits, index out * NUM_PORTS + src
   int             passed [noc_pkg::NUM_PORTS*noc_pkg::NUM_PORTS];
   logic           in_pkt [noc_pkg::NUM_PORTS];
   int             cur_src [noc_pkg::NUM_PORTS];
   logic [31:0]    lcg_state = 32'ha802;
   // Running flit number of each source
   int             seq_no [noc_pkg::NUM_PORTS] = '{default: 0};
   int             errors = 0;
   int             pass_count = 0;
   int             fail_count = 0;
   logic           bp_mode;
   logic           fair_check;
   logic           saw_block;

   noc_router dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_link   (in_link),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_link  (out_link),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // LCG, upper half of the state as result
   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // Output port whose bit is set in the route entry
   function automatic int port_of(input int dest);
      int p;
      p = 0;
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++)
         if (noc_pkg::ROUTE_TABLE[dest][i])
            p = i;
      return p;
   endfunction

   // Flit fields: dest [31:30], source [29:28], index in packet [27:16], seq [15:0]
   function automatic int src_of(input noc_pkg::link_t l);
      return int'(l.flit[29:28]);
   endfunction

   function automatic logic pending(input int s, input int o);
      return rd_idx[s*noc_pkg::NUM_PORTS+o] < exp_q[s*noc_pkg::NUM_PORTS+o].size();
   endfunction

   // Entry idx of the queue for this source and output
   function automatic logic front_matches(input int o, input noc_pkg::link_t l,
                                          input int idx);
      int q;
      q = src_of(l) * noc_pkg::NUM_PORTS + o;
      if (idx >= exp_q[q].size())
         return 1'b0;
      return exp_q[q][idx] == l;
   endfunction

   function automatic logic drained();
      for (int q = 0; q < noc_pkg::NUM_PORTS * noc_pkg::NUM_PORTS; q++)
         if (rd_idx[q] != exp_q[q].size())
            return 1'b0;
      return 1'b1;
   endfunction

   // Called 1 ns after an edge, returns 1 ns after the accepting edge
   task automatic send_flit(input int s, input noc_pkg::link_t l, input int o);
      in_link[s]  = l;
      in_valid[s] = 1'b1;
      while (!in_ready[s]) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
      exp_q[s*noc_pkg::NUM_PORTS+o].push_back(l);
   endtask

   task automatic run_source(input int s, input int mode, input int npkts);
      int             len;
      int             dest;
      noc_pkg::link_t l;
      for (int p = 0; p < npkts; p++) begin
         len = 1 + int'(rand_next() % 32'd4);
         case (mode)
            MODE_ALL_DEST: dest = (s + p) % noc_pkg::NUM_PORTS;
            MODE_HOTSPOT:  dest = int'(rand_next() % 32'd2);
            MODE_FAIR:     dest = 0;
            default:       dest = int'(rand_next() % 32'd4);
         endcase
         for (int f = 0; f < len; f++) begin
            l.flit = {noc_pkg::dest_t'(dest), 2'(s), 12'(f), 16'(seq_no[s])};
            l.last = (f == len - 1);
            seq_no[s]++;
            send_flit(s, l, port_of(dest));
         end
      end
      in_valid[s] = 1'b0;
   endtask

   task automatic run_all(input int mode, input int npkts);
      fork
         run_source(0, mode, npkts);
         run_source(1, mode, npkts);
         run_source(2, mode, npkts);
         run_source(3, mode, npkts);
      join
   endtask

   task automatic wait_drained();
      while (!drained()) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic report_test(input string name, input int mark);
      if (errors == mark) begin
         pass_count++;
         $display("[%0t] test %s passed", $time, name);
      end else begin
         fail_count++;
         $display("[%0t] test %s FAILED with %0d errors", $time, name, errors - mark);
      end
   endtask

   // Scoreboard state, advanced on every accepted output flit
   always @(posedge clk or negedge arst_n) begin
      int s;
      if (!arst_n) begin
         for (int q = 0; q < noc_pkg::NUM_PORTS * noc_pkg::NUM_PORTS; q++) begin
            rd_idx[q] <= 0;
            passed[q] <= 0;
         end
         for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            in_pkt[o]  <= 1'b0;
            cur_src[o] <= 0;
         end
      end else begin
         for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            if (out_valid[o] && out_ready[o]) begin
               s = src_of(out_link[o]);
               rd_idx[s*noc_pkg::NUM_PORTS+o] <= rd_idx[s*noc_pkg::NUM_PORTS+o] + 1;
               in_pkt[o]  <= !out_link[o].last;
               cur_src[o] <= s;
               if (out_link[o].last)
                  for (int k = 0; k < noc_pkg::NUM_PORTS; k++)
                     passed[o*noc_pkg::NUM_PORTS+k] <= (k == s || !pending(k, o)) ? 0 :
                        passed[o*noc_pkg::NUM_PORTS+k] + 1;
            end
         end
      end
   end

   for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : out_checks
      // In order, once, on the routed output
      a_order: assert property (@(posedge clk) disable iff (!arst_n)
         (out_valid[o] && out_ready[o]) |->
            front_matches(o, out_link[o], rd_idx[src_of(out_link[o])*noc_pkg::NUM_PORTS+o]))
         else begin
            $display("MISMATCH at %0t: output %0d flit %h last %b not next expected",
                     $time, o, out_link[o].flit, out_link[o].last);
            errors++;
         end
      a_route: assert property (@(posedge clk) disable iff (!arst_n)
         (out_valid[o] && out_ready[o]) |-> noc_pkg::ROUTE_TABLE[out_link[o].flit[31:30]][o])
         else begin
            $display("MISMATCH at %0t: output %0d carries flit %h of another destination",
                     $time, o, out_link[o].flit);
            errors++;
         end
      // Same source until the flit marked last
      a_no_interleave: assert property (@(posedge clk) disable iff (!arst_n)
         (out_valid[o] && out_ready[o] && in_pkt[o]) |-> (src_of(out_link[o]) == cur_src[o]))
         else begin
            $display("Output %0d switched source in the middle of a packet at %0t", o, $time);
            errors++;
         end
      // No waiting source may see a full round of others go first
      for (genvar k = 0; k < noc_pkg::NUM_PORTS; k++) begin : fair_checks
         a_fair: assert property (@(posedge clk) disable iff (!arst_n)
            (fair_check && out_valid[o] && out_ready[o] && out_link[o].last &&
             src_of(out_link[o]) != k && pending(k, o)) |->
               (passed[o*noc_pkg::NUM_PORTS+k] < noc_pkg::NUM_PORTS - 1))
            else begin
               $display("Output %0d kept waiting input %0d out for a full round at %0t",
                        o, k, $time);
               errors++;
            end
      end
   end

   // Random stalls held for 16 cycles in back-pressure mode
   initial begin : ready_driver
      int hold;
      hold      = 0;
      out_ready = '1;
      forever begin
         @(posedge clk);
         #1;
         if (!bp_mode) begin
            out_ready = '1;
            hold      = 0;
         end else if (hold == 0) begin
            out_ready = noc_pkg::port_mask_t'(rand_next());
            hold      = 15;
         end else begin
            hold--;
         end
      end
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         saw_block <= 1'b0;
      else if (bp_mode && |(in_valid & ~in_ready))
         saw_block <= 1'b1;
   end

   initial begin : watchdog
      #(MAX_FLITS * 40 * CLK_PERIOD + 500 * CLK_PERIOD);
      $display("Run timed out at %0t, flits stopped reaching the outputs", $time);
      $display("Simulation failed");
      $finish;
   end

   initial begin : main
      int mark;
      arst_n     = 1'b0;
      in_link    = '0;
      in_valid   = '0;
      bp_mode    = 1'b0;
      fair_check = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;

      mark = errors;
      a_reset: assert (out_valid == '0 && in_ready == '1)
         else begin
            $display("MISMATCH at %0t: after reset out_valid %b in_ready %b",
                     $time, out_valid, in_ready);
            errors++;
         end
      report_test("reset state", mark);

      mark = errors;
      run_all(MODE_ALL_DEST, 4);
      wait_drained();
      report_test("routing", mark);

      // Two hot outputs shared by all inputs
      mark = errors;
      run_all(MODE_HOTSPOT, 6);
      wait_drained();
      report_test("no interleaving", mark);

      mark = errors;
      fair_check = 1'b1;
      run_all(MODE_FAIR, 6);
      wait_drained();
      fair_check = 1'b0;
      report_test("fairness", mark);

      mark = errors;
      bp_mode = 1'b1;
      run_all(MODE_RANDOM, 10);
      bp_mode = 1'b0;
      wait_drained();
      a_blocked: assert (saw_block)
         else begin
            $display("No input was ever held off by a full buffer under back-pressure");
            errors++;
         end
      report_test("back-pressure", mark);

      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- verilog/noc_fifo.sv
/* Flit buffer, circular store of link payloads
   Valid/ready on both sides, one cycle from write to output */
`timescale 1ns/1ps

module noc_fifo (
   input  logic           clk,
   input  logic           arst_n,
   input  noc_pkg::link_t in_link,
   input  logic           in_valid,
   output logic           in_ready,
   output noc_pkg::link_t out_link,
   output logic           out_valid,
   input  logic           out_ready
);

   noc_pkg::link_t      mem [noc_pkg::BUFFER_DEPTH];
   noc_pkg::buf_addr_t  wr_ptr;
   noc_pkg::buf_addr_t  rd_ptr;
   noc_pkg::buf_count_t count;
   logic                push;
   logic                pop;

   // Pointer advance with wrap at buffer end
   function automatic noc_pkg::buf_addr_t wrap_inc(input noc_pkg::buf_addr_t addr);
      if (addr == noc_pkg::buf_addr_t'(noc_pkg::BUFFER_DEPTH - 1))
         return '0;
      return addr + noc_pkg::buf_addr_t'(1);
   endfunction

   // Full exactly at BUFFER_DEPTH entries
   assign in_ready  = (count != noc_pkg::buf_count_t'(noc_pkg::BUFFER_DEPTH));
   assign out_valid = (count != '0);
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;
   // Head entry always on the output
   assign out_link  = mem[rd_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_link;
   end

   // Pointers and fill level
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wrap_inc(wr_ptr);
         if (pop)
            rd_ptr <= wrap_inc(rd_ptr);
         // Simultaneous read and write keeps the level
         if (push && !pop)
            count <= count + noc_pkg::buf_count_t'(1);
         else if (pop && !push)
            count <= count - noc_pkg::buf_count_t'(1);
      end
   end

   // Fill level never passes the depth
   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      count <= noc_pkg::buf_count_t'(noc_pkg::BUFFER_DEPTH));
   // From empty the level can only grow, never wrap below zero
   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      (count == '0) |=> (count <= noc_pkg::buf_count_t'(1)));

endmodule

//--- verilog/noc_pkg.sv
/* NoC router shared definitions
   Sizes, width typedefs, the link payload and the static route table */
package noc_pkg;

   // Router geometry
   localparam int NUM_PORTS    = 4;
   localparam int FLIT_WIDTH   = 32;
   localparam int DEST_WIDTH   = 2;
   localparam int BUFFER_DEPTH = 4;

   // Derived widths
   localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);
   localparam int ADDR_WIDTH     = $clog2(BUFFER_DEPTH);
   localparam int COUNT_WIDTH    = $clog2(BUFFER_DEPTH + 1);

   // Flit payload and destination field
   typedef logic [FLIT_WIDTH-1:0]     flit_t;
   typedef logic [DEST_WIDTH-1:0]     dest_t;
   // One bit per router port
   typedef logic [NUM_PORTS-1:0]      port_mask_t;
   typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;
   // Buffer pointers and fill level
   typedef logic [ADDR_WIDTH-1:0]     buf_addr_t;
   typedef logic [COUNT_WIDTH-1:0]    buf_count_t;

   // Payload carried on every link
   typedef struct packed {
      flit_t flit;
      logic  last;
   } link_t;

   // Destination to output port, one-hot
   // Identity mapping, dest d leaves on output d
   localparam port_mask_t ROUTE_TABLE [2**DEST_WIDTH] = '{
      4'b0001,
      4'b0010,
      4'b0100,
      4'b1000
   };

endpackage

//--- verilog/noc_router.sv
/* Four-port NoC router top level
   Input and output stages joined by a transposing switch */
`timescale 1ns/1ps

module noc_router (
   input  logic                                    clk,
   input  logic                                    arst_n,
   input  noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] in_link,
   input  noc_pkg::port_mask_t                     in_valid,
   output noc_pkg::port_mask_t                     in_ready,
   output noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] out_link,
   output noc_pkg::port_mask_t                     out_valid,
   input  noc_pkg::port_mask_t                     out_ready
);

   // Input side, one link and one request vector per input
   noc_pkg::link_t      [noc_pkg::NUM_PORTS-1:0] sw_in_link;
   noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] sw_in_req;
   noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] sw_in_ready;
   // Output side, one bit per input
   noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] sw_out_valid;
   noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] sw_out_ready;

   for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : inputs
      noc_router_input u_input (
         .clk         (clk),
         .arst_n      (arst_n),
         .in_link     (in_link[i]),
         .in_valid    (in_valid[i]),
         .in_ready    (in_ready[i]),
         .out_link    (sw_in_link[i]),
         .out_request (sw_in_req[i]),
         .out_ready   (sw_in_ready[i])
      );
   end

   // Transpose requests toward outputs and readies back to inputs
   for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : switch_cols
      for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : switch_rows
         assign sw_out_valid[o][i] = sw_in_req[i][o];
         assign sw_in_ready[i][o]  = sw_out_ready[o][i];
      end
   end

   // Every output sees all input links
   for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : outputs
      noc_router_output u_output (
         .clk       (clk),
         .arst_n    (arst_n),
         .in_link   (sw_in_link),
         .in_valid  (sw_out_valid[o]),
         .in_ready  (sw_out_ready[o]),
         .out_link  (out_link[o]),
         .out_valid (out_valid[o]),
         .out_ready (out_ready[o])
      );
   end

endmodule

//--- verilog/noc_router_input.sv
/* Router input stage
   Buffers flits, routes the head flit and holds the route for the packet */
`timescale 1ns/1ps

module noc_router_input (
   input  logic                clk,
   input  logic                arst_n,
   input  noc_pkg::link_t      in_link,
   input  logic                in_valid,
   output logic                in_ready,
   output noc_pkg::link_t      out_link,
   output noc_pkg::port_mask_t out_request,
   input  noc_pkg::port_mask_t out_ready
);

   typedef enum logic {
      HEAD,
      BODY
   } state_t;

   state_t              state;
   noc_pkg::link_t      buf_link;
   logic                buf_valid;
   logic                buf_ready;
   logic                xfer;
   noc_pkg::dest_t      head_dest;
   noc_pkg::port_mask_t head_route;
   noc_pkg::port_mask_t route_q;
   noc_pkg::port_mask_t cur_route;

   noc_fifo u_buffer (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_link   (in_link),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_link  (buf_link),
      .out_valid (buf_valid),
      .out_ready (buf_ready)
   );

   // Destination sits in the top bits of the head flit
   assign head_dest  = buf_link.flit[noc_pkg::FLIT_WIDTH-1 -: noc_pkg::DEST_WIDTH];
   assign head_route = noc_pkg::ROUTE_TABLE[head_dest];
   // Fresh decode on the head, held route on the body
   assign cur_route  = (state == HEAD) ? head_route : route_q;

   assign out_request = buf_valid ? cur_route : '0;
   assign out_link    = buf_link;
   // Pop only on ready of the routed output
   assign buf_ready   = |(out_request & out_ready);
   assign xfer        = buf_valid && buf_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= HEAD;
         route_q <= '0;
      end else begin
         case (state)
            HEAD: begin
               // Single-flit packet leaving now needs no held route
               if (buf_valid && !(xfer && buf_link.last)) begin
                  route_q <= head_route;
                  state   <= BODY;
               end
            end
            BODY: begin
               if (xfer && buf_link.last) begin
                  route_q <= '0;
                  state   <= HEAD;
               end
            end
            default: state <= HEAD;
         endcase
      end
   end

   // Never more than one output requested
   a_req_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(out_request));
   // A waiting request keeps its target and payload
   a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (|out_request && !buf_ready) |=> ($stable(out_request) && $stable(out_link)));

endmodule

//--- verilog/noc_router_output.sv
/* Router output stage
   Round-robin arbiter with packet lock, input mux and output buffer */
`timescale 1ns/1ps

module noc_router_output (
   input  logic                                    clk,
   input  logic                                    arst_n,
   input  noc_pkg::link_t [noc_pkg::NUM_PORTS-1:0] in_link,
   input  noc_pkg::port_mask_t                     in_valid,
   output noc_pkg::port_mask_t                     in_ready,
   output noc_pkg::link_t                          out_link,
   output logic                                    out_valid,
   input  logic                                    out_ready
);

   noc_pkg::port_mask_t arb_grant;
   noc_pkg::port_mask_t grant;
   noc_pkg::port_mask_t grant_q;
   noc_pkg::port_idx_t  grant_idx;
   noc_pkg::port_idx_t  last_q;
   logic                locked_q;
   noc_pkg::link_t      sel_link;
   logic                sel_valid;
   logic                buf_ready;
   logic                xfer;

   // Search starts after the last served input
   always_comb begin : arbiter
      int   idx;
      logic found;
      found     = 1'b0;
      arb_grant = '0;
      for (int k = 1; k <= noc_pkg::NUM_PORTS; k++) begin
         idx = (int'(last_q) + k) % noc_pkg::NUM_PORTS;
         if (!found && in_valid[idx]) begin
            arb_grant[idx] = 1'b1;
            found          = 1'b1;
         end
      end
   end

   // Locked grant wins for the rest of a packet
   assign grant = locked_q ? grant_q : arb_grant;

   // Switch mux onto the buffer input
   always_comb begin : input_mux
      sel_link  = '0;
      grant_idx = '0;
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
         if (grant[i]) begin
            sel_link  = in_link[i];
            grant_idx = noc_pkg::port_idx_t'(i);
         end
      end
   end

   assign sel_valid = |(grant & in_valid);
   // Ready only to the granted input, only with room
   assign in_ready  = grant & {noc_pkg::NUM_PORTS{buf_ready}};
   assign xfer      = sel_valid && buf_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         locked_q <= 1'b0;
         grant_q  <= '0;
         // Port 0 served first after reset
         last_q   <= noc_pkg::port_idx_t'(noc_pkg::NUM_PORTS - 1);
      end else if (xfer) begin
         if (sel_link.last) begin
            // Packet done, release and move the pointer on
            locked_q <= 1'b0;
            grant_q  <= '0;
            last_q   <= grant_idx;
         end else if (!locked_q) begin
            locked_q <= 1'b1;
            grant_q  <= grant;
         end
      end
   end

   noc_fifo u_buffer (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_link   (sel_link),
      .in_valid  (sel_valid),
      .in_ready  (buf_ready),
      .out_link  (out_link),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // One input at a time
   a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(grant));
   // No switch of source in the middle of a packet
   a_grant_locked: assert property (@(posedge clk) disable iff (!arst_n)
      (locked_q && !(xfer && sel_link.last)) |=> $stable(grant));

endmodule
